// ==== dac_cmd_pkg.sv ====
package dac_cmd_pkg;

	////////////////////////////////////////////////////////////
	// field widths
	////////////////////////////////////////////////////////////

	localparam int data_width  = 16;                 // dac code width
	localparam int num_chans   = 8;                  // output channels on the part
	localparam int chan_width  = $clog2(num_chans);  // channel select width, 3
	localparam int addr_width  = 4;                  // address nibble in the instruction
	localparam int instr_width = 32;                 // serial word length

	// bit counter for the transmit phase
	localparam int bit_cnt_width = $clog2(instr_width);
	localparam logic [bit_cnt_width-1:0] last_bit = bit_cnt_width'(instr_width - 1);

	typedef logic [data_width-1:0] dac_code_t;
	typedef logic [chan_width-1:0] dac_chan_t;

	////////////////////////////////////////////////////////////
	// instruction nibbles
	////////////////////////////////////////////////////////////

	localparam logic [3:0] prefix_bits       = 4'b0000;  // leading don't-care nibble
	localparam logic [3:0] ctrl_write_update = 4'b0011;  // write channel register and update
	localparam logic [3:0] ctrl_ref_setup    = 4'b1001;  // internal reference setup
	localparam logic [3:0] ref_always_on     = 4'b1010;  // reference mode, always powered
	localparam logic [3:0] feature_bits      = 4'b0000;  // trailing feature nibble

	// fixed word for the reference command, 090A0000 hex
	localparam logic [instr_width-1:0] ref_set_word = {
		prefix_bits,
		ctrl_ref_setup,
		4'b0000,          // address field unused here
		ref_always_on,
		16'h0000
	};

endpackage

// ==== dac_link_pkg.sv ====
package dac_link_pkg;

	////////////////////////////////////////////////////////////
	// command entry carried from issuer to transmitter
	////////////////////////////////////////////////////////////

	typedef enum logic {
		cmd_data = 1'b0,  // channel write
		cmd_ref  = 1'b1   // internal reference setup
	} cmd_kind_t;

	// 20 bits: kind, channel, code
	typedef struct packed {
		cmd_kind_t             kind;
		dac_cmd_pkg::dac_chan_t chan;
		dac_cmd_pkg::dac_code_t code;
	} dac_entry_t;

	////////////////////////////////////////////////////////////
	// buffer and credit sizing
	////////////////////////////////////////////////////////////

	localparam int fifo_depth   = 4;
	localparam int ptr_width    = $clog2(fifo_depth);  // read/write pointer width
	localparam int credit_width = 3;                   // counts 0 .. fifo_depth

endpackage

// ==== dac_cmd_issuer.sv ====
module dac_cmd_issuer
	import dac_cmd_pkg::*;
	import dac_link_pkg::*;
(
	input  logic       clk_in,
	input  logic       reset_in,
	input  dac_code_t  data_in,        // host code
	input  dac_chan_t  channel_in,     // host channel
	input  logic       data_valid_in,  // host offers a write
	input  logic       ref_set_in,     // one-cycle reference request
	input  logic       credit,         // buffer released one slot
	output logic       ready,          // at least one credit held
	output logic       push,           // entry valid toward buffer
	output dac_entry_t entry
);

	logic [credit_width-1:0] credits;  // free slots in the buffer
	logic                    ref_pending;
	logic                    wr_accept;
	logic                    ref_issue;
	logic                    spend;

	////////////////////////////////////////////////////////////
	// arbitration
	////////////////////////////////////////////////////////////

	assign ready = (credits != '0);

	// host write wins, reference waits for a free cycle
	assign wr_accept = data_valid_in && ready;
	assign ref_issue = ref_pending && ready && !wr_accept;
	assign spend     = wr_accept || ref_issue;  // a credit is used at decision time

	////////////////////////////////////////////////////////////
	// credit counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			credits <= credit_width'(fifo_depth);  // buffer starts empty
		end else begin
			case ({spend, credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;  // both or neither, no change
			endcase
		end
	end

	// sticky reference request, a new pulse wins over the clear
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			ref_pending <= 1'b0;
		end else begin
			ref_pending <= ref_set_in || (ref_pending && !ref_issue);
		end
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			push <= 1'b0;
		end else begin
			push <= spend;  // one cycle after the decision
		end
	end

	// payload only, qualified by push
	always_ff @(posedge clk_in) begin
		if (wr_accept) begin
			entry.kind <= cmd_data;
			entry.chan <= channel_in;
			entry.code <= data_in;
		end else if (ref_issue) begin
			entry.kind <= cmd_ref;
			entry.chan <= '0;  // ignored for reference commands
			entry.code <= '0;
		end
	end

endmodule

// ==== dac_cmd_fifo.sv ====
module dac_cmd_fifo
	import dac_link_pkg::*;
#(
	parameter type payload_t = dac_entry_t
) (
	input  logic     clk_in,
	input  logic     reset_in,
	input  logic     push,      // write wr_entry, never when full
	input  payload_t wr_entry,
	input  logic     pop,       // release the head entry
	output payload_t rd_entry,  // head of the buffer
	output logic     nonempty,
	output logic     credit     // one pulse per released entry
);

	payload_t                mem [fifo_depth];
	logic [ptr_width-1:0]    wr_ptr;
	logic [ptr_width-1:0]    rd_ptr;
	logic [credit_width-1:0] count;  // occupancy
	logic                    pop_ok;

	assign nonempty = (count != '0);
	assign rd_entry = mem[rd_ptr];
	assign pop_ok   = pop && nonempty;  // ignore a pop on an empty buffer

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (push) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	////////////////////////////////////////////////////////////
	// pointers, occupancy and credit return
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps at fifo_depth
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			credit <= pop_ok;  // slot handed back the cycle after the pop
		end
	end

endmodule

// ==== dac_serial_tx.sv ====
module dac_serial_tx
	import dac_cmd_pkg::*;
	import dac_link_pkg::*;
(
	input  logic       clk_in,
	input  logic       reset_in,
	input  dac_entry_t rd_entry,     // buffer head
	input  logic       nonempty,
	output logic       pop,          // take the head entry
	output logic       nsync,        // frame strobe, low while shifting
	output logic       sclk,         // serial clock to the dac
	output logic       din,          // serial data, msb first
	output logic       nldac,        // load pin
	output logic       nclr,         // clear pin
	output logic       dac_done,     // one cycle after each command
	output dac_code_t  data_out,     // last written code
	output dac_chan_t  channel_out   // last written channel
);

	// load is not a state of its own, it happens in the idle cycle that pops
	typedef enum logic [1:0] {
		st_idle,
		st_tx,
		st_done
	} tx_state_t;

	tx_state_t               state;
	logic                    load;       // pop and load shift register
	logic                    tx_flag;    // registered, high for the 32 shift cycles
	logic [bit_cnt_width-1:0] bit_cnt;
	logic [instr_width-1:0]  shreg;      // outgoing instruction
	logic [instr_width-1:0]  data_word;
	logic [instr_width-1:0]  next_word;

	////////////////////////////////////////////////////////////
	// instruction forming
	////////////////////////////////////////////////////////////

	assign data_word = {
		prefix_bits,
		ctrl_write_update,
		{{(addr_width - chan_width){1'b0}}, rd_entry.chan},  // top address bit is broadcast
		rd_entry.code,
		feature_bits
	};

	assign next_word = (rd_entry.kind == cmd_ref) ? ref_set_word : data_word;

	assign load = (state == st_idle) && nonempty;
	assign pop  = load;

	////////////////////////////////////////////////////////////
	// pins
	////////////////////////////////////////////////////////////

	assign nldac    = 1'b0;  // synchronous update mode, ldac tied low
	assign nclr     = 1'b1;  // never clear
	assign nsync    = !tx_flag;
	assign sclk     = tx_flag ? clk_in : 1'b1;  // falls mid-cycle, din already stable
	assign din      = shreg[instr_width-1];
	assign dac_done = (state == st_done);

	////////////////////////////////////////////////////////////
	// state machine and bit counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state   <= st_idle;
			tx_flag <= 1'b0;
			bit_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (load) begin
						state   <= st_tx;
						tx_flag <= 1'b1;  // nsync falls with bit 31 on din
						bit_cnt <= '0;
					end
				end
				st_tx: begin
					if (bit_cnt == last_bit) begin
						state   <= st_done;
						tx_flag <= 1'b0;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				st_done: begin
					state <= st_idle;  // single done cycle
				end
				default: begin
					state   <= st_idle;
					tx_flag <= 1'b0;
				end
			endcase
		end
	end

	// shift register, msb leaves first
	always_ff @(posedge clk_in) begin
		if (load) begin
			shreg <= next_word;
		end else if (tx_flag) begin
			shreg <= {shreg[instr_width-2:0], 1'b0};
		end
	end

	// report the last channel write, reference commands leave it alone
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_out    <= '0;
			channel_out <= '0;
		end else if (load && (rd_entry.kind == cmd_data)) begin
			data_out    <= rd_entry.code;
			channel_out <= rd_entry.chan;
		end
	end

endmodule

// ==== dac_subsystem_top.sv ====
module dac_subsystem_top
	import dac_cmd_pkg::*;
	import dac_link_pkg::*;
(
	input  logic      clk_in,
	input  logic      reset_in,
	// host side
	input  dac_code_t data_in,
	input  dac_chan_t channel_in,
	input  logic      data_valid_in,
	output logic      ready,
	input  logic      ref_set_in,
	// dac pins
	output logic      nldac,
	output logic      nsync,
	output logic      sclk,
	output logic      din,
	output logic      nclr,
	// status
	output logic      dac_done,
	output dac_code_t data_out,
	output dac_chan_t channel_out
);

	logic       push;       // issuer -> buffer
	dac_entry_t wr_entry;
	logic       credit;     // buffer -> issuer
	logic       pop;        // transmitter -> buffer
	dac_entry_t rd_entry;
	logic       nonempty;

	////////////////////////////////////////////////////////////
	// producer, buffer, consumer
	////////////////////////////////////////////////////////////

	dac_cmd_issuer issuer0 (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.data_in       (data_in),
		.channel_in    (channel_in),
		.data_valid_in (data_valid_in),
		.ref_set_in    (ref_set_in),
		.credit        (credit),
		.ready         (ready),
		.push          (push),
		.entry         (wr_entry)
	);

	dac_cmd_fifo #(
		.payload_t (dac_entry_t)
	) fifo0 (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.push     (push),
		.wr_entry (wr_entry),
		.pop      (pop),
		.rd_entry (rd_entry),
		.nonempty (nonempty),
		.credit   (credit)
	);

	dac_serial_tx tx0 (
		.clk_in      (clk_in),
		.reset_in    (reset_in),
		.rd_entry    (rd_entry),
		.nonempty    (nonempty),
		.pop         (pop),
		.nsync       (nsync),
		.sclk        (sclk),
		.din         (din),
		.nldac       (nldac),
		.nclr        (nclr),
		.dac_done    (dac_done),
		.data_out    (data_out),
		.channel_out (channel_out)
	);

endmodule

// ==== dac_subsystem_tb.sv ====
module dac_subsystem_tb
	import dac_cmd_pkg::*;
	import dac_link_pkg::*;
();

	localparam int period     = 20;
	localparam int wait_limit = 400;  // cycles per wait loop

	logic        clk_in = 1'b0;
	logic        reset_in;
	dac_code_t   data_in;
	dac_chan_t   channel_in;
	logic        data_valid_in;
	logic        ref_set_in;
	logic        ready;
	logic        nldac;
	logic        nsync;
	logic        sclk;
	logic        din;
	logic        nclr;
	logic        dac_done;
	dac_code_t   data_out;
	dac_chan_t   channel_out;

	integer      seed = 32'ha707e503;
	int          errors = 0;
	dac_entry_t  sb_q[$];            // expected commands, issue order
	logic        ref_model;          // host view of the sticky reference request
	int          issued = 0;         // commands put on the scoreboard
	int          frames = 0;         // serial words seen
	int          done_pulses = 0;
	int          ref_seen = 0;       // captured reference words
	int          low_cnt = 0;        // clk_in cycles with nsync low
	int          nbits = 0;          // sclk falling edges in this frame
	logic [31:0] shift_word;
	logic        prev_done = 1'b0;
	dac_code_t   last_code = '0;     // expected data_out
	dac_chan_t   last_chan = '0;

	dac_subsystem_top dut0 (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.data_in       (data_in),
		.channel_in    (channel_in),
		.data_valid_in (data_valid_in),
		.ready         (ready),
		.ref_set_in    (ref_set_in),
		.nldac         (nldac),
		.nsync         (nsync),
		.sclk          (sclk),
		.din           (din),
		.nclr          (nclr),
		.dac_done      (dac_done),
		.data_out      (data_out),
		.channel_out   (channel_out)
	);

	always #(period / 2) clk_in = ~clk_in;

	////////////////////////////////////////////////////////////
	// reference model and checker
	////////////////////////////////////////////////////////////

	// 0000, control, address, code, feature
	function automatic logic [31:0] expected_word(input cmd_kind_t kind, input dac_chan_t chan,
			input dac_code_t code);
		if (kind == cmd_ref) begin
			return 32'h090a_0000;  // reference setup, always on
		end
		return {4'b0000, 4'b0011, 1'b0, chan, code, 4'b0000};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// host side, inputs are stable at the falling edge
	always @(negedge clk_in) begin : watch_host
		dac_entry_t e;
		if (reset_in) begin
			ref_model = 1'b0;
		end else begin
			if (data_valid_in && ready) begin  // write wins the cycle
				e.kind = cmd_data;
				e.chan = channel_in;
				e.code = data_in;
				sb_q.push_back(e);
				issued++;
			end else if (ref_model && ready) begin
				e.kind = cmd_ref;
				e.chan = '0;
				e.code = '0;
				sb_q.push_back(e);
				issued++;
				ref_model = 1'b0;
			end
			if (ref_set_in) begin
				ref_model = 1'b1;  // sticky until issued
			end
		end
	end

	// serial capture
	always @(negedge nsync) begin
		nbits = 0;
	end

	always @(negedge sclk) begin
		if (nsync === 1'b0) begin
			shift_word = {shift_word[30:0], din};  // msb arrives first
			nbits++;
		end
	end

	// frame end and done pulse checks
	always @(negedge clk_in) begin : compare_words
		dac_entry_t exp_e;
		if (!reset_in) begin
			if (dac_done === 1'b1) begin
				done_pulses++;
				if (prev_done) begin
					$display("dac_done stayed high for more than one cycle at %0t", $time);
					errors++;
				end
			end
			prev_done = (dac_done === 1'b1);
			if (nsync === 1'b0) begin
				low_cnt++;
			end else if (low_cnt != 0) begin  // nsync rose at the last edge
				frames++;
				check_value("nsync low cycles", low_cnt, 32);
				check_value("sclk falling edges", nbits, 32);
				check_value("dac_done", dac_done, 1'b1);
				if (shift_word == 32'h090a_0000) begin
					ref_seen++;
				end
				if (sb_q.size() == 0) begin
					$display("a serial word arrived with no command expected at %0t", $time);
					errors++;
				end else begin
					exp_e = sb_q.pop_front();
					check_value("din word", shift_word,
						expected_word(exp_e.kind, exp_e.chan, exp_e.code));
					if (exp_e.kind == cmd_data) begin
						last_code = exp_e.code;
						last_chan = exp_e.chan;
					end
					check_value("data_out", data_out, last_code);
					check_value("channel_out", channel_out, last_chan);
				end
				low_cnt = 0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// host tasks
	////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk_in);
		#2;
	endtask

	// hold the write until ready, then one accepting edge
	task automatic write_cmd(input dac_chan_t chan, input dac_code_t code);
		int t;
		t = 0;
		data_valid_in = 1'b1;
		channel_in    = chan;
		data_in       = code;
		while (!ready && t < wait_limit) begin
			next_cycle();
			t++;
		end
		if (!ready) begin
			$display("timeout: ready never rose for a host write at %0t", $time);
			errors++;
		end else begin
			next_cycle();
		end
		data_valid_in = 1'b0;
	endtask

	task automatic pulse_ref();
		ref_set_in = 1'b1;
		next_cycle();
		ref_set_in = 1'b0;
	endtask

	task automatic wait_frame_start();
		int t;
		t = 0;
		while (nsync !== 1'b0 && t < wait_limit) begin
			next_cycle();
			t++;
		end
		if (nsync !== 1'b0) begin
			$display("timeout: nsync never went low at %0t", $time);
			errors++;
		end
	endtask

	function automatic bit all_idle();
		return sb_q.size() == 0 && ref_model !== 1'b1 && nsync === 1'b1 && dac_done === 1'b0;
	endfunction

	// every queued command sent and the transmitter back in idle
	task automatic drain();
		int t;
		t = 0;
		while (!all_idle() && t < wait_limit) begin
			next_cycle();
			t++;
		end
		if (!all_idle()) begin
			$display("timeout: commands still outstanding at %0t", $time);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		int          ref_before;
		int          done_before;
		logic [31:0] r;
		reset_in      = 1'b1;
		data_in       = '0;
		channel_in    = '0;
		data_valid_in = 1'b0;
		ref_set_in    = 1'b0;
		repeat (2) @(posedge clk_in);
		#2;
		reset_in = 1'b0;

		check_value("nsync", nsync, 1'b1);  // outputs idle after reset
		check_value("sclk", sclk, 1'b1);
		check_value("nclr", nclr, 1'b1);
		check_value("nldac", nldac, 1'b0);
		check_value("dac_done", dac_done, 1'b0);
		check_value("ready", ready, 1'b1);
		check_value("data_out", data_out, 16'h0000);
		check_value("channel_out", channel_out, 3'd0);

		write_cmd(3'd5, 16'hbeef);  // single data write
		drain();
		check_value("data_out", data_out, 16'hbeef);
		check_value("channel_out", channel_out, 3'd5);

		done_before = done_pulses;  // reference request alone
		ref_before  = ref_seen;
		pulse_ref();
		drain();
		check_value("dac_done pulses", done_pulses - done_before, 1);
		check_value("reference words", ref_seen - ref_before, 1);
		check_value("data_out", data_out, 16'hbeef);  // untouched by the reference
		check_value("channel_out", channel_out, 3'd5);

		write_cmd(3'd1, 16'h1111);  // keeps the transmitter busy
		wait_frame_start();
		repeat (2) next_cycle();  // credit for the popped entry is back
		for (int i = 0; i < fifo_depth; i++) begin
			check_value("ready", ready, 1'b1);
			write_cmd(dac_chan_t'(i), dac_code_t'(16'h2000 + i));
		end
		check_value("ready", ready, 1'b0);  // buffer full
		write_cmd(3'd6, 16'h3333);  // waits for a credit
		write_cmd(3'd7, 16'h4444);
		drain();

		ref_before = ref_seen;  // reference request inside a burst
		write_cmd(3'd0, 16'h5000);
		write_cmd(3'd2, 16'h5001);
		ref_set_in = 1'b1;
		write_cmd(3'd4, 16'h5002);  // request lands with this write
		ref_set_in = 1'b0;
		write_cmd(3'd3, 16'h5003);
		write_cmd(3'd5, 16'h5004);
		write_cmd(3'd6, 16'h5005);
		drain();
		check_value("reference words", ref_seen - ref_before, 1);

		done_before = done_pulses;  // random traffic
		for (int n = 0; n < 40; n++) begin
			r = $random(seed);
			if (r[2:0] == 3'd0 && ref_model !== 1'b1) begin
				pulse_ref();
			end else begin
				write_cmd(dac_chan_t'(r[10:8]), dac_code_t'(r[31:16]));
			end
			repeat (r[5:4]) next_cycle();  // idle gap
		end
		drain();
		check_value("dac_done pulses", done_pulses - done_before, 40);

		check_value("commands left", sb_q.size(), 0);
		check_value("serial words", frames, issued);
		check_value("dac_done pulses", done_pulses, frames);
		$display("%0d commands, %0d serial words, %0d errors", issued, frames, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== src.f ====
dac_cmd_pkg.sv
dac_link_pkg.sv
dac_cmd_issuer.sv
dac_cmd_fifo.sv
dac_serial_tx.sv
dac_subsystem_top.sv
dac_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: dac_subsystem

sources:
  - files:
      - dac_cmd_pkg.sv
      - dac_link_pkg.sv
      - dac_cmd_issuer.sv
      - dac_cmd_fifo.sv
      - dac_serial_tx.sv
      - dac_subsystem_top.sv
  - target: test
    files:
      - dac_subsystem_tb.sv
